// File: files.f
fpMulPkg.sv
fpMulPrep.sv
fpMulExecute.sv
fpMulRound.sv
fpMulCore.sv
fpMulResultBuffer.sv
fpMulTop.sv
fpMul_assert.sv
tb_fpMul.sv

// File: fpMulCore.sv
module fpMulCore
	import fpMulPkg::*;
(
	input  logic     aclk,
	input  logic     rst,
	input  logic     inValid,
	input  HalfWord  inA,
	input  HalfWord  inB,
	output logic     coreValid,
	output MulResult coreResult
);

	// Stage 0 operands
	logic     opValid;
	HalfWord  opA;
	HalfWord  opB;
	// Stage 1 and 2 registers
	logic     prepValid;
	PrepStage prepReg;
	logic     execValid;
	ExecStage execReg;
	// Combinational stage outputs
	PrepStage prepNext;
	ExecStage execNext;

	fpMulPrep i_prep (
		.a    (opA),
		.b    (opB),
		.prep (prepNext)
	);

	fpMulExecute i_execute (
		.prep (prepReg),
		.exec (execNext)
	);

	fpMulRound i_round (
		.exec   (execReg),
		.result (coreResult) // Straight off the last register
	);

	// Valid bits walk down with the data, no stall
	always_ff @(posedge aclk) begin
		if (rst) begin
			opValid   <= 1'b0;
			prepValid <= 1'b0;
			execValid <= 1'b0;
		end else begin
			opValid   <= inValid;
			prepValid <= opValid;
			execValid <= prepValid;
		end
	end

	// Payload only loads behind a valid
	always_ff @(posedge aclk) begin
		if (inValid) begin
			opA <= inA;
			opB <= inB;
		end
		if (opValid)
			prepReg <= prepNext;
		if (prepValid)
			execReg <= execNext;
	end

	assign coreValid = execValid; // Written to buffer at edge N+3

endmodule

// File: fpMulExecute.sv
module fpMulExecute
	import fpMulPkg::*;
(
	input  PrepStage prep,
	output ExecStage exec
);

	logic    topBit;   // Product is in [2,4)
	WideExpo expoSum;

	assign topBit = prep.prod[2*FracWidth+1];

	// Unsigned arithmetic at 7 bits wraps into the signed range
	assign expoSum = WideExpo'({2'b00, prep.expA}) + WideExpo'({2'b00, prep.expB})
		+ WideExpo'(topBit) - WideExpo'(ExpBias);

	always_comb begin
		exec.sign = prep.signA ^ prep.signB; // Equal signs give positive
		exec.expo = expoSum;

		if (topBit) begin // Shift right by one
			exec.frac   = prep.prod[2*FracWidth:FracWidth+1];
			exec.guard  = prep.prod[FracWidth];
			exec.sticky = |prep.prod[FracWidth-1:0];
		end else begin
			exec.frac   = prep.prod[2*FracWidth-1:FracWidth];
			exec.guard  = prep.prod[FracWidth-1];
			exec.sticky = |prep.prod[FracWidth-2:0];
		end

		// Classes pass straight through to round
		exec.aNaN  = prep.aNaN;
		exec.bNaN  = prep.bNaN;
		exec.aInf  = prep.aInf;
		exec.bInf  = prep.bInf;
		exec.aZero = prep.aZero;
		exec.bZero = prep.bZero;
	end

endmodule

// File: fpMulPkg.sv
package fpMulPkg;

	// binary16 field layout
	localparam int ExpWidth  = 5;
	localparam int FracWidth = 10;
	localparam int ExpBias   = 15;
	localparam int ExpMax    = (1 << ExpWidth) - 2; // Largest finite biased exponent

	localparam logic [15:0] QuietNaN = 16'h7E00; // Canonical quiet NaN

	// Result buffer entries, also the upstream credits after reset
	localparam int ResultDepth = 8;
	localparam int PtrWidth    = $clog2(ResultDepth);

	typedef logic [ExpWidth+FracWidth:0]   HalfWord;   // Sign, exponent, fraction
	typedef logic [ExpWidth-1:0]           Expo;       // Biased exponent
	typedef logic [FracWidth-1:0]          Frac;       // Stored fraction
	typedef logic [FracWidth:0]            Signif;     // Fraction with hidden bit
	typedef logic [2*FracWidth+1:0]        SignifProd; // Full significand product
	typedef logic signed [ExpWidth+1:0]    WideExpo;   // Exponent sum, may leave 1..30
	typedef logic [PtrWidth:0]             CreditCount; // Counts up to ResultDepth

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
		logic inputSpecial; // NaN or infinity on an input
	} FpFlags;

	// Prep to execute
	typedef struct packed {
		logic      signA;
		logic      signB;
		Expo       expA;
		Expo       expB;
		SignifProd prod;
		logic      aNaN;
		logic      bNaN;
		logic      aInf;
		logic      bInf;
		logic      aZero; // Includes flushed subnormals
		logic      bZero;
	} PrepStage;

	// Execute to round
	typedef struct packed {
		logic    sign;
		WideExpo expo;   // Normalized, still unrounded
		Frac     frac;   // Kept fraction bits
		logic    guard;  // First dropped bit
		logic    sticky; // OR of everything below guard
		logic    aNaN;
		logic    bNaN;
		logic    aInf;
		logic    bInf;
		logic    aZero;
		logic    bZero;
	} ExecStage;

	typedef struct packed {
		HalfWord product;
		FpFlags  flags;
	} MulResult;

endpackage

// File: fpMulPrep.sv
module fpMulPrep
	import fpMulPkg::*;
(
	input  HalfWord  a,
	input  HalfWord  b,
	output PrepStage prep
);

	Expo   expA;
	Expo   expB;
	Frac   fracA;
	Frac   fracB;
	Signif sigA;
	Signif sigB;

	// Field split
	assign expA  = a[ExpWidth+FracWidth-1:FracWidth];
	assign expB  = b[ExpWidth+FracWidth-1:FracWidth];
	assign fracA = a[FracWidth-1:0];
	assign fracB = b[FracWidth-1:0];

	// Hidden bit only for normal numbers
	assign sigA = {|expA, fracA};
	assign sigB = {|expB, fracB};

	always_comb begin
		prep.signA = a[ExpWidth+FracWidth];
		prep.signB = b[ExpWidth+FracWidth];
		prep.expA  = expA;
		prep.expB  = expB;
		prep.prod  = SignifProd'(sigA) * SignifProd'(sigB); // 11x11 unsigned

		// All-ones exponent is NaN or infinity depending on the fraction
		prep.aNaN  = (&expA) & (|fracA);
		prep.bNaN  = (&expB) & (|fracB);
		prep.aInf  = (&expA) & ~(|fracA);
		prep.bInf  = (&expB) & ~(|fracB);
		// Subnormals flushed, so fraction is ignored here
		prep.aZero = ~(|expA);
		prep.bZero = ~(|expB);
	end

endmodule

// File: fpMulResultBuffer.sv
module fpMulResultBuffer
	import fpMulPkg::*;
(
	input  logic     aclk,
	input  logic     rst,
	input  logic     coreValid,
	input  MulResult coreResult,
	input  logic     creditIn,
	output logic     outValid,
	output MulResult outResult,
	output logic     creditOut
);

	MulResult              mem [ResultDepth];
	logic [PtrWidth-1:0]   wrPtr;
	logic [PtrWidth-1:0]   rdPtr;
	CreditCount            fillCount; // Entries held in the FIFO
	CreditCount            credits;   // Downstream credits
	logic                  creditOk;
	logic                  pop;

	// The item on the output this cycle still owns its credit
	assign creditOk = credits > CreditCount'(outValid);
	assign pop      = (fillCount != '0) && creditOk;

	// Upstream sizing keeps the FIFO from overflowing
	always_ff @(posedge aclk) begin
		if (coreValid)
			mem[wrPtr] <= coreResult;
		if (pop)
			outResult <= mem[rdPtr]; // Head item into the output slot
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fillCount <= '0;
			outValid  <= 1'b0;
		end else begin
			if (coreValid)
				wrPtr <= wrPtr + 1'b1; // Wraps at depth 8
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({coreValid, pop})
				2'b10:   fillCount <= fillCount + 1'b1;
				2'b01:   fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;
			endcase
			outValid <= pop; // One cycle per item sent
		end
	end

	// Spend on outValid, refill on creditIn
	always_ff @(posedge aclk) begin
		if (rst) begin
			credits <= CreditCount'(ResultDepth);
		end else begin
			case ({creditIn, outValid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Slot freed upstream as the item leaves
	assign creditOut = outValid;

endmodule

// File: fpMulRound.sv
module fpMulRound
	import fpMulPkg::*;
(
	input  ExecStage exec,
	output MulResult result
);

	logic                 roundUp;
	logic [FracWidth+1:0] roundedSig; // One extra bit for the carry
	logic                 carry;
	Frac                  finalFrac;
	WideExpo              finalExp;
	logic                 isNaN;
	logic                 isInf;
	logic                 isZero;
	logic                 inexact;

	// Nearest even: up past the tie, or on the tie when LSB is odd
	assign roundUp    = exec.guard & (exec.sticky | exec.frac[0]);
	assign roundedSig = {1'b0, 1'b1, exec.frac} + {{(FracWidth+1){1'b0}}, roundUp};
	assign carry      = roundedSig[FracWidth+1];

	// Post-rounding renormalization, 1.11..1 + ulp becomes 10.0
	assign finalFrac = carry ? roundedSig[FracWidth:1] : roundedSig[FracWidth-1:0];
	assign finalExp  = exec.expo + WideExpo'(carry);
	assign inexact   = exec.guard | exec.sticky;

	// Exception classes of the inputs
	assign isNaN  = exec.aNaN | exec.bNaN | (exec.aInf & exec.bZero) | (exec.bInf & exec.aZero);
	assign isInf  = exec.aInf | exec.bInf;
	assign isZero = exec.aZero | exec.bZero;

	always_comb begin
		result.flags   = '0;
		result.product = {exec.sign, finalExp[ExpWidth-1:0], finalFrac}; // Normal case

		if (isNaN) begin
			result.product            = QuietNaN;
			result.flags.invalid      = 1'b1;
			result.flags.inputSpecial = 1'b1;
		end else if (isInf) begin
			result.product            = {exec.sign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}};
			result.flags.inputSpecial = 1'b1;
		end else if (isZero) begin
			// Exact zero, also for flushed subnormals
			result.product = {exec.sign, {(ExpWidth+FracWidth){1'b0}}};
		end else if (finalExp > WideExpo'(ExpMax)) begin
			result.product         = {exec.sign, {ExpWidth{1'b1}}, {FracWidth{1'b0}}};
			result.flags.overflow  = 1'b1;
			result.flags.inexact   = 1'b1;
		end else if (finalExp < WideExpo'(1)) begin
			// No gradual underflow, straight to zero
			result.product         = {exec.sign, {(ExpWidth+FracWidth){1'b0}}};
			result.flags.underflow = 1'b1;
			result.flags.inexact   = 1'b1;
		end else begin
			result.flags.inexact = inexact;
		end
	end

endmodule

// File: fpMulTop.sv
module fpMulTop
	import fpMulPkg::*;
(
	input  logic     aclk,
	input  logic     rst,
	input  logic     inValid,
	input  HalfWord  inA,
	input  HalfWord  inB,
	input  logic     creditIn,
	output logic     outValid,
	output MulResult outResult,
	output logic     creditOut
);

	logic     coreValid;
	MulResult coreResult;

	// Fixed three-cycle datapath
	fpMulCore i_core (
		.aclk       (aclk),
		.rst        (rst),
		.inValid    (inValid),
		.inA        (inA),
		.inB        (inB),
		.coreValid  (coreValid),
		.coreResult (coreResult)
	);

	// Holds results until downstream has credit
	fpMulResultBuffer i_buffer (
		.aclk       (aclk),
		.rst        (rst),
		.coreValid  (coreValid),
		.coreResult (coreResult),
		.creditIn   (creditIn),
		.outValid   (outValid),
		.outResult  (outResult),
		.creditOut  (creditOut)
	);

endmodule

// File: fpMul_assert.sv
module fpMulAssert
	import fpMulPkg::*;
(
	input logic aclk,
	input logic rst,
	input logic outValid,
	input logic creditIn,
	input logic creditOut
);

	CreditCount heldCredits; // Downstream credits as the receiver counts them
	int         sentCount;
	int         returnCount;

	always_ff @(posedge aclk) begin
		if (rst) begin
			heldCredits <= CreditCount'(ResultDepth);
			sentCount   <= 0;
			returnCount <= 0;
		end else begin
			heldCredits <= heldCredits + CreditCount'(creditIn) - CreditCount'(outValid);
			if (outValid)
				sentCount <= sentCount + 1;
			if (creditOut)
				returnCount <= returnCount + 1; // Upstream credit per item sent
		end
	end

	creditHeld: assert property (@(posedge aclk) disable iff (rst)
		outValid |-> heldCredits != '0)
		else $error("outValid with no downstream credit held");

	creditBalance: assert property (@(posedge aclk) disable iff (rst)
		sentCount == returnCount)
		else $error("creditOut count %0d differs from outValid count %0d", returnCount, sentCount);

	// Nothing leaves right out of reset
	quietAfterReset: assert property (@(posedge aclk) rst |=> !outValid)
		else $error("outValid high right after reset");

endmodule

bind fpMulTop fpMulAssert i_assert (
	.aclk      (aclk),
	.rst       (rst),
	.outValid  (outValid),
	.creditIn  (creditIn),
	.creditOut (creditOut)
);

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f files.f --top-module tb_fpMul -o tb_fpMul \
	&& ./obj_dir/tb_fpMul | tee sim.log \
	&& grep -q "^Regression passed$" sim.log \
	&& echo "Simulation OK" \
	|| { echo "Simulation FAILED"; exit 1; }

// File: tb_fpMul.sv
module tb_fpMul
	import fpMulPkg::*;
();

	typedef struct packed {
		HalfWord a;
		HalfWord b;
		HalfWord expProduct;
		FpFlags  expFlags;
	} VecEntry;

	logic        aclk;
	logic        rst;
	logic        inValid;
	HalfWord     inA;
	HalfWord     inB;
	logic        creditIn;
	logic        outValid;
	MulResult    outResult;
	logic        creditOut;

	VecEntry     vecTable [$];
	string       vecName [$];
	int          expectQ [$];        // Table indices in send order
	logic [15:0] lfsr;
	int          upCredits;          // Held by the sender
	int          sentCount;
	int          rxCount;
	int          creditInCount;      // Returned downstream so far
	int          creditOutCount;
	int          pendingReturns;     // Consumed and not yet credited
	int          firstAccept;        // Edge that took the first input
	int          edgeCount = 0;
	int          mismatchCount = 0;
	int          protocolCount = 0;

	fpMulTop i_dut (
		.aclk      (aclk),
		.rst       (rst),
		.inValid   (inValid),
		.inA       (inA),
		.inB       (inB),
		.creditIn  (creditIn),
		.outValid  (outValid),
		.outResult (outResult),
		.creditOut (creditOut)
	);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	always @(posedge aclk) edgeCount <= edgeCount + 1;

	// Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBit(output logic b);
		lfsr = lfsrStep(lfsr);
		b    = lfsr[0];
	endtask

	// Set about one time in eight
	task automatic rareBit(output logic b);
		logic b0;
		logic b1;
		logic b2;
		randomBit(b0);
		randomBit(b1);
		randomBit(b2);
		b = b0 & b1 & b2;
	endtask

	task automatic addVector(input string name, input HalfWord a, input HalfWord b,
			input HalfWord expProduct, input logic [4:0] expFlags);
		VecEntry entry;
		entry.a          = a;
		entry.b          = b;
		entry.expProduct = expProduct;
		entry.expFlags   = expFlags;
		vecTable.push_back(entry);
		vecName.push_back(name);
	endtask

	// Flags column holds invalid overflow underflow inexact inputSpecial
	task automatic loadTable();
		addVector("onePointFiveTimesTwo", 16'h3E00, 16'h4000, 16'h4200, 5'b00000);
		addVector("negTimesPos",          16'hC000, 16'h3E00, 16'hC200, 5'b00000);
		addVector("negTimesNeg",          16'hBC00, 16'hC400, 16'h4400, 5'b00000);
		addVector("threeSquared",         16'h4200, 16'h4200, 16'h4880, 5'b00000); // Top bit set
		addVector("tieStaysEven",         16'h3C03, 16'h3E00, 16'h3E04, 5'b00010);
		addVector("tieRoundsToEven",      16'h3C01, 16'h3E00, 16'h3E02, 5'b00010); // Odd LSB
		addVector("aboveTieRoundsUp",     16'h3C01, 16'h3E01, 16'h3E03, 5'b00010);
		addVector("roundCarryRenorm",     16'h3DA8, 16'h3DA8, 16'h4000, 5'b00010); // 1.11..1 up
		addVector("overflowPos",          16'h7BFF, 16'h4000, 16'h7C00, 5'b01010);
		addVector("overflowNeg",          16'h7800, 16'hC000, 16'hFC00, 5'b01010);
		addVector("underflowPos",         16'h0400, 16'h3800, 16'h0000, 5'b00110);
		addVector("underflowNeg",         16'h8400, 16'h3800, 16'h8000, 5'b00110);
		addVector("subnormalIn",          16'h0001, 16'h3C00, 16'h0000, 5'b00000); // Flushed
		addVector("subnormalNeg",         16'h8200, 16'h4000, 16'h8000, 5'b00000);
		addVector("zeroTimesNeg",         16'h0000, 16'hC200, 16'h8000, 5'b00000);
		addVector("nanOperandA",          16'h7E00, 16'h3C00, 16'h7E00, 5'b10001);
		addVector("nanOperandB",          16'h4000, 16'h7C01, 16'h7E00, 5'b10001);
		addVector("infTimesZero",         16'h7C00, 16'h0000, 16'h7E00, 5'b10001);
		addVector("negZeroTimesInf",      16'h8000, 16'hFC00, 16'h7E00, 5'b10001);
		addVector("infTimesNeg",          16'h7C00, 16'hC000, 16'hFC00, 5'b00001);
		addVector("negInfTimesNeg",       16'hFC00, 16'hBC00, 16'h7C00, 5'b00001);
		addVector("infTimesInf",          16'h7C00, 16'hFC00, 16'hFC00, 5'b00001);
	endtask

	// Ordered compare against the oldest outstanding vector
	task automatic checkResult();
		int idx;
		if (expectQ.size() == 0) begin
			$display("Result %h arrived with no input outstanding", outResult.product);
			protocolCount++;
		end else begin
			idx = expectQ.pop_front();
			if (outResult.product !== vecTable[idx].expProduct) begin
				$display("Mismatch %s: expected product %h, actual %h", vecName[idx],
					vecTable[idx].expProduct, outResult.product);
				mismatchCount++;
			end
			if (outResult.flags !== vecTable[idx].expFlags) begin
				$display("Mismatch %s: expected flags %b, actual %b", vecName[idx],
					vecTable[idx].expFlags, outResult.flags);
				mismatchCount++;
			end
		end
	endtask

	task automatic watchOutputs();
		if (outValid) begin
			if (sentCount == 0) begin
				$display("outValid rose before any input was sent");
				protocolCount++;
			end else if (rxCount == 0 && edgeCount - firstAccept != 4) begin
				$display("First result took %0d cycles, expected 4", edgeCount - firstAccept);
				protocolCount++;
			end
			if (rxCount + 1 > ResultDepth + creditInCount) begin
				$display("outValid raised with no downstream credit left");
				protocolCount++;
			end
			checkResult();
			rxCount++;
			pendingReturns++; // Credit goes back later
		end
		if (creditOut) begin
			creditOutCount++;
			upCredits++;
		end
	endtask

	// Random gaps on both sides
	task automatic driveInputs();
		logic go;
		inValid  = 1'b0;
		creditIn = 1'b0;
		if (sentCount < vecTable.size() && upCredits > 0) begin
			randomBit(go);
			if (go) begin
				inValid = 1'b1;
				inA     = vecTable[sentCount].a;
				inB     = vecTable[sentCount].b;
				expectQ.push_back(sentCount);
				if (sentCount == 0)
					firstAccept = edgeCount + 1; // Taken at the next rising edge
				sentCount++;
				upCredits--;
			end
		end
		// Returns slower than sends so both credit pools run dry
		if (pendingReturns > 0) begin
			rareBit(go);
			if (go) begin
				creditIn = 1'b1;
				creditInCount++;
				pendingReturns--;
			end
		end
	endtask

	initial begin
		rst            = 1'b1;
		inValid        = 1'b0;
		inA            = '0;
		inB            = '0;
		creditIn       = 1'b0;
		lfsr           = 16'd72;
		upCredits      = ResultDepth;
		sentCount      = 0;
		rxCount        = 0;
		creditInCount  = 0;
		creditOutCount = 0;
		pendingReturns = 0;
		firstAccept    = 0;
		loadTable();
		repeat (5) @(negedge aclk);
		rst = 1'b0;

		while (rxCount < vecTable.size() || pendingReturns > 0) begin
			@(negedge aclk);
			watchOutputs();
			driveInputs();
		end

		// Quiet tail where any late item is an extra
		repeat (10) begin
			@(negedge aclk);
			watchOutputs();
			inValid  = 1'b0;
			creditIn = 1'b0;
		end

		if (rxCount != vecTable.size()) begin
			$display("Received %0d results for %0d inputs", rxCount, vecTable.size());
			protocolCount++;
		end
		if (creditOutCount != rxCount) begin
			$display("creditOut pulsed %0d times for %0d results", creditOutCount, rxCount);
			protocolCount++;
		end
		if (upCredits != ResultDepth) begin
			$display("Sender ended with %0d credits instead of %0d", upCredits, ResultDepth);
			protocolCount++;
		end

		$display("Errors: %0d mismatches, %0d protocol errors", mismatchCount, protocolCount);
		if (mismatchCount == 0 && protocolCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		int limit;
		wait (rst === 1'b0);
		limit = vecTable.size() * 40 + 100;
		repeat (limit) @(posedge aclk);
		$display("Timeout: results still missing after %0d cycles", limit);
		$display("Regression failed");
		$finish;
	end

endmodule
